/* rtl/kbd_settings.svh */
// Default repeat timings and counter widths for the keyboard front end, include where needed
`ifndef KBD_SETTINGS_SVH
`define KBD_SETTINGS_SVH

// ========================================
// Repeat timing defaults in CLK12 cycles
// ========================================

// Length of one key-down pulse, 25 ms at 12 MHz
`define KBD_PULSE_CYCLES 300000

// First pulse start to first repeat
`define KBD_FIRST_DELAY 2000000

// Repeat period while the key stays held
`define KBD_REPEAT_DELAY 500000

// ========================================
// Widths
// ========================================

`define KBD_TIMER_BITS 24 // Wide enough for the first delay

`endif

/* rtl/kbd_pkg.sv */
// Shared key-code, scan-code, key-class and repeat-state types for the keyboard front end
package kbd_pkg;

	// ========================================
	// Codes
	// ========================================

	typedef logic [6:0] ascii_t; // Machine key code
	typedef logic [8:0] scancode_t; // Extended flag on top of PS/2 byte

	// ========================================
	// Decoder and controller enums
	// ========================================

	// What a single strobed scan code means
	typedef enum logic [2:0] {
		KC_NONE, // No strobe or unlisted combination
		KC_SHIFT, // Either shift key
		KC_CTRL, // Either ctrl key
		KC_UPCASE, // Upcase toggle key
		KC_CHAR // Translated character
	} key_class_e;

	typedef enum logic [1:0] {
		RS_IDLE, // No key held
		RS_WAIT_FIRST, // Counting the first delay
		RS_WAIT_REPEAT // Counting a repeat period
	} repeat_state_e;

endpackage

/* rtl/key_scan_decoder.sv */
// Scan-code translator: classifies each strobed PS/2 code and latches the machine key code
`timescale 1ns/100ps

module key_scan_decoder (
	input  logic                   CLK12,
	input  logic                   RESET,
	input  logic                   strobe,
	input  logic                   pressed,
	input  kbd_pkg::scancode_t     scan,
	input  logic                   shift,
	input  logic                   ctrl,
	input  logic                   upcase,
	output kbd_pkg::key_class_e    key_class,
	output logic                   key_flag,
	output logic                   held,
	output kbd_pkg::ascii_t        code
);

	kbd_pkg::key_class_e cls;
	kbd_pkg::ascii_t     xlat;
	kbd_pkg::ascii_t     lc_mask;

	// Letters go lower case unless exactly one of shift and upcase is on
	assign lc_mask = {1'b0, shift == upcase, 5'd0};

	// ========================================
	// Translation table
	// ========================================

	always_comb begin
		cls = kbd_pkg::KC_CHAR;
		xlat = '0;
		casez ({ctrl, shift, scan})
			{2'b??, 9'h012}: cls = kbd_pkg::KC_SHIFT; // Left shift
			{2'b??, 9'h059}: cls = kbd_pkg::KC_SHIFT; // Right shift
			{2'b??, 9'h?14}: cls = kbd_pkg::KC_CTRL; // Both ctrl keys
			{2'b??, 9'h058}: cls = kbd_pkg::KC_UPCASE;

			{2'b0?, 9'h01C}: xlat = 7'h41 | lc_mask; // A
			{2'b0?, 9'h032}: xlat = 7'h42 | lc_mask; // B
			{2'b0?, 9'h021}: xlat = 7'h43 | lc_mask; // C
			{2'b0?, 9'h023}: xlat = 7'h44 | lc_mask; // D
			{2'b0?, 9'h024}: xlat = 7'h45 | lc_mask; // E
			{2'b0?, 9'h02B}: xlat = 7'h46 | lc_mask; // F
			{2'b0?, 9'h034}: xlat = 7'h47 | lc_mask; // G
			{2'b0?, 9'h033}: xlat = 7'h48 | lc_mask; // H
			{2'b0?, 9'h043}: xlat = 7'h49 | lc_mask; // I
			{2'b0?, 9'h03B}: xlat = 7'h4A | lc_mask; // J
			{2'b0?, 9'h042}: xlat = 7'h4B | lc_mask; // K
			{2'b0?, 9'h04B}: xlat = 7'h4C | lc_mask; // L
			{2'b0?, 9'h03A}: xlat = 7'h4D | lc_mask; // M
			{2'b0?, 9'h031}: xlat = 7'h4E | lc_mask; // N
			{2'b0?, 9'h044}: xlat = 7'h4F | lc_mask; // O
			{2'b0?, 9'h04D}: xlat = 7'h50 | lc_mask; // P
			{2'b0?, 9'h015}: xlat = 7'h51 | lc_mask; // Q
			{2'b0?, 9'h02D}: xlat = 7'h52 | lc_mask; // R
			{2'b0?, 9'h01B}: xlat = 7'h53 | lc_mask; // S
			{2'b0?, 9'h02C}: xlat = 7'h54 | lc_mask; // T
			{2'b0?, 9'h03C}: xlat = 7'h55 | lc_mask; // U
			{2'b0?, 9'h02A}: xlat = 7'h56 | lc_mask; // V
			{2'b0?, 9'h01D}: xlat = 7'h57 | lc_mask; // W
			{2'b0?, 9'h022}: xlat = 7'h58 | lc_mask; // X
			{2'b0?, 9'h035}: xlat = 7'h59 | lc_mask; // Y
			{2'b0?, 9'h01A}: xlat = 7'h5A | lc_mask; // Z

			// National letters on the bracket and quote keys
			{2'b0?, 9'h055}: xlat = 7'h40 | lc_mask;
			{2'b0?, 9'h054}: xlat = 7'h5D | lc_mask;
			{2'b0?, 9'h05B}: xlat = 7'h5E | lc_mask;
			{2'b0?, 9'h04C}: xlat = 7'h5C | lc_mask;
			{2'b0?, 9'h052}: xlat = 7'h5B | lc_mask;

			{2'b00, 9'h016}: xlat = 7'h31; // Top row digits
			{2'b00, 9'h01E}: xlat = 7'h32;
			{2'b00, 9'h026}: xlat = 7'h33;
			{2'b00, 9'h025}: xlat = 7'h34;
			{2'b00, 9'h02E}: xlat = 7'h35;
			{2'b00, 9'h036}: xlat = 7'h36;
			{2'b00, 9'h03D}: xlat = 7'h37;
			{2'b00, 9'h03E}: xlat = 7'h38;
			{2'b00, 9'h046}: xlat = 7'h39;
			{2'b00, 9'h045}: xlat = 7'h30;

			{2'b00, 9'h069}: xlat = 7'h31; // Keypad digits
			{2'b00, 9'h072}: xlat = 7'h32;
			{2'b00, 9'h07A}: xlat = 7'h33;
			{2'b00, 9'h06B}: xlat = 7'h34;
			{2'b00, 9'h073}: xlat = 7'h35;
			{2'b00, 9'h074}: xlat = 7'h36;
			{2'b00, 9'h06C}: xlat = 7'h37;
			{2'b00, 9'h075}: xlat = 7'h38;
			{2'b00, 9'h07D}: xlat = 7'h39;
			{2'b00, 9'h070}: xlat = 7'h30;

			{2'b01, 9'h016}: xlat = 7'h21; // Shifted digit row
			{2'b01, 9'h01E}: xlat = 7'h22;
			{2'b01, 9'h026}: xlat = 7'h23;
			{2'b01, 9'h025}: xlat = 7'h24;
			{2'b01, 9'h02E}: xlat = 7'h25;
			{2'b01, 9'h036}: xlat = 7'h26;
			{2'b01, 9'h03D}: xlat = 7'h27;
			{2'b01, 9'h03E}: xlat = 7'h28;
			{2'b01, 9'h046}: xlat = 7'h29;
			{2'b01, 9'h045}: xlat = 7'h3D;

			{2'b00, 9'h?5A}: xlat = 7'h0D; // Enter, main or keypad
			{2'b00, 9'h029}: xlat = 7'h20; // Space
			{2'b00, 9'h066}: xlat = 7'h08; // Backspace
			{2'b00, 9'h16B}: xlat = 7'h08; // Cursor left
			{2'b00, 9'h174}: xlat = 7'h09; // Cursor right
			{2'b10, 9'h021}: xlat = 7'h03; // Ctrl+C
			{2'b10, 9'h022}: xlat = 7'h18; // Ctrl+X
			{2'b1?, 9'h00E}: xlat = 7'h7F; // Ctrl+backtick

			{2'b00, 9'h041}: xlat = 7'h2C; // Punctuation, plain
			{2'b00, 9'h049}: xlat = 7'h2E;
			{2'b00, 9'h04A}: xlat = 7'h2D;
			{2'b00, 9'h04E}: xlat = 7'h2B;
			{2'b00, 9'h05D}: xlat = 7'h27;
			{2'b00, 9'h00E}: xlat = 7'h3C;
			{2'b01, 9'h041}: xlat = 7'h3B; // Punctuation, shifted
			{2'b01, 9'h049}: xlat = 7'h3A;
			{2'b01, 9'h04A}: xlat = 7'h5F;
			{2'b01, 9'h04E}: xlat = 7'h3F;
			{2'b01, 9'h05D}: xlat = 7'h2A;
			{2'b01, 9'h00E}: xlat = 7'h3E;

			default: cls = kbd_pkg::KC_NONE;
		endcase
		if (!strobe) begin
			cls = kbd_pkg::KC_NONE;
		end
	end

	assign key_class = cls;
	assign key_flag = strobe & pressed; // Make or break travels with the class

	// ========================================
	// Latched character and held level
	// ========================================

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			held <= 1'b0;
			code <= '0;
		end else if (cls == kbd_pkg::KC_CHAR) begin
			held <= pressed;
			code <= xlat;
		end
	end

endmodule

/* rtl/key_modifier_state.sv */
// Shift, ctrl and upcase flags, updated from the decoder's modifier-class strobes
`timescale 1ns/100ps

module key_modifier_state (
	input  logic                CLK12,
	input  logic                RESET,
	input  kbd_pkg::key_class_e key_class,
	input  logic                key_flag,
	output logic                shift,
	output logic                ctrl,
	output logic                upcase
);

	// ========================================
	// Shift and ctrl follow make and break
	// ========================================

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			shift <= 1'b0;
			ctrl <= 1'b0;
		end else begin
			if (key_class == kbd_pkg::KC_SHIFT) begin
				shift <= key_flag; // Either shift key
			end
			if (key_class == kbd_pkg::KC_CTRL) begin
				ctrl <= key_flag;
			end
		end
	end

	// ========================================
	// Upcase toggle
	// ========================================

	// Only the make code flips the flag, the break code is ignored
	always_ff @(posedge CLK12) begin
		if (RESET) begin
			upcase <= 1'b0;
		end else if (key_class == kbd_pkg::KC_UPCASE && key_flag) begin
			upcase <= ~upcase;
		end
	end

endmodule

/* rtl/key_pulse_timer.sv */
// Key-down pulse and repeat delay down-counters, loaded by the repeat controller's commands
`timescale 1ns/100ps
`include "kbd_settings.svh"

module key_pulse_timer #(
	parameter int unsigned PULSE_CYCLES = `KBD_PULSE_CYCLES,
	parameter int unsigned FIRST_DELAY = `KBD_FIRST_DELAY,
	parameter int unsigned REPEAT_DELAY = `KBD_REPEAT_DELAY
) (
	input  logic CLK12,
	input  logic RESET,
	input  logic start_pulse,
	input  logic start_repeat,
	input  logic arm_first,
	output logic key_down,
	output logic delay_done
);

	localparam int TW = `KBD_TIMER_BITS;
	localparam logic [TW-1:0] PULSE_LOAD = TW'(PULSE_CYCLES);
	localparam logic [TW-1:0] FIRST_LOAD = TW'(FIRST_DELAY);
	localparam logic [TW-1:0] REPEAT_LOAD = TW'(REPEAT_DELAY);

	logic [TW-1:0] pulse_cnt;
	logic [TW-1:0] delay_cnt;

	// ========================================
	// Pulse length counter
	// ========================================

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			pulse_cnt <= '0;
		end else if (start_pulse || start_repeat) begin
			pulse_cnt <= PULSE_LOAD;
		end else if (pulse_cnt != '0) begin
			pulse_cnt <= pulse_cnt - 1'b1;
		end
	end

	assign key_down = (pulse_cnt != '0); // High for exactly PULSE_CYCLES

	// ========================================
	// Delay counter
	// ========================================

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			delay_cnt <= '0;
		end else if (start_pulse) begin
			delay_cnt <= arm_first ? FIRST_LOAD : REPEAT_LOAD;
		end else if (start_repeat) begin
			delay_cnt <= REPEAT_LOAD;
		end else if (delay_cnt != '0) begin
			delay_cnt <= delay_cnt - 1'b1;
		end
	end

	assign delay_done = (delay_cnt == TW'(1)); // Last cycle before zero

endmodule

/* rtl/key_repeat_ctrl.sv */
// Auto-repeat FSM: starts a pulse on each new press and schedules repeats while the key is held
`timescale 1ns/100ps

module key_repeat_ctrl (
	input  logic CLK12,
	input  logic RESET,
	input  logic held,
	input  logic delay_done,
	output logic start_pulse,
	output logic start_repeat,
	output logic arm_first
);

	kbd_pkg::repeat_state_e state;
	kbd_pkg::repeat_state_e state_nxt;
	logic                   held_d;
	logic                   rise;

	// ========================================
	// Press detection
	// ========================================

	assign rise = held & ~held_d; // New press from the decoder

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			held_d <= 1'b0;
		end else begin
			held_d <= held;
		end
	end

	// ========================================
	// State machine
	// ========================================

	always_comb begin
		state_nxt = state;
		case (state)
			kbd_pkg::RS_IDLE: begin
				state_nxt = kbd_pkg::RS_IDLE; // Counter idle, nothing to wait for
			end
			kbd_pkg::RS_WAIT_FIRST,
			kbd_pkg::RS_WAIT_REPEAT: begin
				if (delay_done) begin
					state_nxt = held ? kbd_pkg::RS_WAIT_REPEAT : kbd_pkg::RS_IDLE;
				end
			end
			default: begin
				state_nxt = kbd_pkg::RS_IDLE;
			end
		endcase
		// A fresh press restarts the sequence from any state
		if (rise) begin
			state_nxt = kbd_pkg::RS_WAIT_FIRST;
		end
	end

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			state <= kbd_pkg::RS_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// ========================================
	// Timer commands
	// ========================================

	assign start_pulse = rise;
	assign arm_first = rise; // First delay only after a new press
	assign start_repeat = delay_done & held & ~rise & (state != kbd_pkg::RS_IDLE);

endmodule

/* rtl/abc80_keyboard.sv */
// Keyboard front end top level: PS/2 strobes in, machine key code and repeating key-down pulse out
`timescale 1ns/100ps
`include "kbd_settings.svh"

module abc80_keyboard #(
	parameter int unsigned PULSE_CYCLES = `KBD_PULSE_CYCLES,
	parameter int unsigned FIRST_DELAY = `KBD_FIRST_DELAY,
	parameter int unsigned REPEAT_DELAY = `KBD_REPEAT_DELAY
) (
	input  logic            CLK12,
	input  logic            RESET,
	input  logic            key_strobe,
	input  logic            key_pressed,
	input  logic            key_extended,
	input  logic [7:0]      key_code, // PS/2 scan code byte
	output kbd_pkg::ascii_t key_ascii,
	output logic            key_down,
	output logic            upcase
);

	kbd_pkg::key_class_e key_class;
	logic                key_flag;
	logic                held;
	logic                shift;
	logic                ctrl;
	logic                start_pulse;
	logic                start_repeat;
	logic                arm_first;
	logic                delay_done;

	// ========================================
	// Decode and modifiers
	// ========================================

	key_scan_decoder i_decoder (
		.CLK12     (CLK12),
		.RESET     (RESET),
		.strobe    (key_strobe),
		.pressed   (key_pressed),
		.scan      ({key_extended, key_code}),
		.shift     (shift),
		.ctrl      (ctrl),
		.upcase    (upcase),
		.key_class (key_class),
		.key_flag  (key_flag),
		.held      (held),
		.code      (key_ascii)
	);

	key_modifier_state i_modifiers (
		.CLK12     (CLK12),
		.RESET     (RESET),
		.key_class (key_class),
		.key_flag  (key_flag),
		.shift     (shift),
		.ctrl      (ctrl),
		.upcase    (upcase)
	);

	// ========================================
	// Key-down pulse and auto-repeat
	// ========================================

	key_repeat_ctrl i_repeat (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.held         (held),
		.delay_done   (delay_done),
		.start_pulse  (start_pulse),
		.start_repeat (start_repeat),
		.arm_first    (arm_first)
	);

	key_pulse_timer #(
		.PULSE_CYCLES (PULSE_CYCLES),
		.FIRST_DELAY  (FIRST_DELAY),
		.REPEAT_DELAY (REPEAT_DELAY)
	) i_timer (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.start_pulse  (start_pulse),
		.start_repeat (start_repeat),
		.arm_first    (arm_first),
		.key_down     (key_down),
		.delay_done   (delay_done)
	);

endmodule

/* test/abc80_keyboard_sva.sv */
// Concurrent checks on the keyboard top level outputs, bound into every abc80_keyboard instance
`timescale 1ns/100ps
`include "kbd_settings.svh"

module abc80_keyboard_sva #(
	parameter int unsigned PULSE_CYCLES = `KBD_PULSE_CYCLES
) (
	input logic            CLK12,
	input logic            RESET,
	input logic            key_strobe,
	input kbd_pkg::ascii_t key_ascii,
	input logic            key_down,
	input logic            upcase
);

	int unsigned high_run; // Earlier consecutive cycles with key_down high
	int          failures = 0; // Assertion failures so far

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			high_run <= 0;
		end else if (key_down) begin
			high_run <= high_run + 1;
		end else begin
			high_run <= 0;
		end
	end

	// ========================================
	// Output properties
	// ========================================

	a_pulse_length: assert property (@(posedge CLK12) disable iff (RESET)
		key_down |-> (high_run < PULSE_CYCLES))
		else begin
			$error("key_down stayed high longer than one pulse");
			failures++;
		end

	a_code_after_strobe: assert property (@(posedge CLK12) disable iff (RESET)
		(key_ascii != $past(key_ascii)) |-> $past(key_strobe))
		else begin
			$error("key_ascii changed without a strobe");
			failures++;
		end

	a_reset_idle: assert property (@(posedge CLK12)
		$past(RESET) |-> (!key_down && !upcase))
		else begin
			$error("key_down or upcase high right after reset");
			failures++;
		end

endmodule

bind abc80_keyboard abc80_keyboard_sva #(
	.PULSE_CYCLES (PULSE_CYCLES)
) i_sva (
	.CLK12      (CLK12),
	.RESET      (RESET),
	.key_strobe (key_strobe),
	.key_ascii  (key_ascii),
	.key_down   (key_down),
	.upcase     (upcase)
);

/* test/tb_abc80_keyboard.sv */
// Directed testbench for the keyboard front end, used as the simulation top with the file list
`timescale 1ns/100ps
`include "kbd_settings.svh"

module tb_abc80_keyboard;

	localparam int PULSE = 12; // Short timings for simulation
	localparam int FIRST = 60;
	localparam int REPEAT = 30;

	logic            CLK12;
	logic            RESET;
	logic            key_strobe;
	logic            key_pressed;
	logic            key_extended;
	logic [7:0]      key_code;
	kbd_pkg::ascii_t key_ascii;
	logic            key_down;
	logic            upcase;

	int errors;
	int checks;
	int tests;
	int errors_at_start;

	abc80_keyboard #(
		.PULSE_CYCLES (PULSE),
		.FIRST_DELAY  (FIRST),
		.REPEAT_DELAY (REPEAT)
	) i_dut (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code     (key_code),
		.key_ascii    (key_ascii),
		.key_down     (key_down),
		.upcase       (upcase)
	);

	always #50 CLK12 = ~CLK12; // 100 ns period

	// ========================================
	// Stimulus and compare tasks
	// ========================================

	task automatic next_cycle();
		@(posedge CLK12);
		#10; // Drive and sample after the edge
	endtask

	task automatic press_key(input logic [7:0] code, input logic ext, input logic pressed);
		key_code = code;
		key_extended = ext;
		key_pressed = pressed;
		key_strobe = 1'b1;
		next_cycle();
		key_strobe = 1'b0;
	endtask

	task automatic compare_ascii(input string name, input kbd_pkg::ascii_t exp,
		input kbd_pkg::ascii_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic compare_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	// Cycles until key_down reaches the level, bounded by limit
	task automatic wait_level(input logic level, input int limit, output int waited);
		waited = 0;
		while (key_down !== level && waited < limit) begin
			next_cycle();
			waited++;
		end
		if (key_down !== level) begin
			errors++;
			$display("Timeout at %0t: key_down did not go to %b within %0d cycles",
				$time, level, limit);
		end
	endtask

	task automatic type_key(input logic [7:0] code, input logic ext, input kbd_pkg::ascii_t exp);
		int waited;
		press_key(code, ext, 1'b1);
		compare_ascii("key_ascii", exp, key_ascii);
		press_key(code, ext, 1'b0);
		wait_level(1'b0, 2 * PULSE, waited); // Pulse ends before the next key
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == errors_at_start) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic reset_state();
		compare_bit("key_down", 1'b0, key_down);
		compare_bit("upcase", 1'b0, upcase);
		compare_ascii("key_ascii", 7'h00, key_ascii);
		finish_test("reset");
	endtask

	task automatic letter_case();
		type_key(8'h1C, 1'b0, 7'h61); // Plain A is lower case
		press_key(8'h12, 1'b0, 1'b1);
		type_key(8'h1C, 1'b0, 7'h41);
		press_key(8'h12, 1'b0, 1'b0);
		press_key(8'h58, 1'b0, 1'b1); // Upcase on
		compare_bit("upcase", 1'b1, upcase);
		press_key(8'h58, 1'b0, 1'b0);
		compare_bit("upcase", 1'b1, upcase);
		type_key(8'h1C, 1'b0, 7'h41);
		press_key(8'h59, 1'b0, 1'b1); // Right shift flips back to lower
		type_key(8'h1C, 1'b0, 7'h61);
		press_key(8'h59, 1'b0, 1'b0);
		press_key(8'h58, 1'b0, 1'b1);
		press_key(8'h58, 1'b0, 1'b0);
		compare_bit("upcase", 1'b0, upcase);
		finish_test("letter_case");
	endtask

	task automatic digit_keys();
		type_key(8'h16, 1'b0, 7'h31);
		press_key(8'h12, 1'b0, 1'b1);
		type_key(8'h16, 1'b0, 7'h21); // Shifted 1
		press_key(8'h12, 1'b0, 1'b0);
		type_key(8'h70, 1'b0, 7'h30); // Keypad 0
		type_key(8'h74, 1'b1, 7'h09);
		type_key(8'h6B, 1'b1, 7'h08);
		type_key(8'h5A, 1'b1, 7'h0D);
		finish_test("digits_and_extended");
	endtask

	task automatic ctrl_keys(input logic ext);
		press_key(8'h14, ext, 1'b1);
		type_key(8'h21, 1'b0, 7'h03);
		type_key(8'h22, 1'b0, 7'h18);
		press_key(8'h1C, 1'b0, 1'b1); // Ctrl+A has no code
		compare_ascii("key_ascii", 7'h18, key_ascii); // Still ctrl+X
		press_key(8'h1C, 1'b0, 1'b0);
		press_key(8'h14, ext, 1'b0);
		if (ext) begin
			finish_test("ctrl_extended");
		end else begin
			finish_test("ctrl");
		end
	endtask

	task automatic pulse_timing();
		int   waited;
		logic seen;
		wait_level(1'b0, 2 * PULSE, waited); // Earlier pulses finish
		press_key(8'h1C, 1'b0, 1'b1);
		wait_level(1'b1, 2, waited);
		compare_count("first pulse start", 1, waited);
		wait_level(1'b0, 2 * PULSE, waited);
		compare_count("pulse length", PULSE, waited);
		wait_level(1'b1, 2 * FIRST, waited);
		compare_count("first repeat gap", FIRST - PULSE, waited);
		wait_level(1'b0, 2 * PULSE, waited);
		compare_count("pulse length", PULSE, waited);
		repeat (2) begin
			wait_level(1'b1, 2 * REPEAT, waited);
			compare_count("repeat gap", REPEAT - PULSE, waited);
			wait_level(1'b0, 2 * PULSE, waited);
			compare_count("pulse length", PULSE, waited);
		end
		press_key(8'h1C, 1'b0, 1'b0); // Release stops repeats
		seen = 1'b0;
		repeat (100) begin
			next_cycle();
			seen = seen | key_down;
		end
		compare_bit("key_down after release", 1'b0, seen);
		finish_test("pulse_timing");
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		CLK12 = 1'b0;
		RESET = 1'b1;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_extended = 1'b0;
		key_code = 8'h00;
		errors = 0;
		checks = 0;
		tests = 0;
		errors_at_start = 0;
		repeat (16) next_cycle();
		RESET = 1'b0;
		reset_state();
		letter_case();
		digit_keys();
		ctrl_keys(1'b0);
		ctrl_keys(1'b1);
		pulse_timing();
		errors += i_dut.i_sva.failures; // Bound assertion failures
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+rtl
rtl/kbd_pkg.sv
rtl/key_scan_decoder.sv
rtl/key_modifier_state.sv
rtl/key_pulse_timer.sv
rtl/key_repeat_ctrl.sv
rtl/abc80_keyboard.sv
test/abc80_keyboard_sva.sv
test/tb_abc80_keyboard.sv
